//--- rtl/lsu_pkg.sv
package lsu_pkg;

	// ########################################
	// Widths
	// ########################################

	localparam int XLEN    = 32;
	localparam int WADDR_W = XLEN - 2;        // Word address, byte offset dropped
	localparam int STRB_W  = XLEN / 8;

	// ########################################
	// Encodings
	// ########################################

	typedef enum logic [3:0] {
		OP_PASS,
		OP_LB,
		OP_LH,
		OP_LW,
		OP_LBU,
		OP_LHU,
		OP_SB,
		OP_SH,
		OP_SW
	} lsu_op_e;

	typedef enum logic [0:0] {BANK_IDLE, BANK_RESP} bank_state_e;

	typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_WB} lsu_state_e;

	// ########################################
	// Records
	// ########################################

	typedef struct packed {
		lsu_op_e           op;
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;                 // Store data, not yet lane shifted
		logic [4:0]        rd;
		logic [XLEN-1:0]   alu_val;
		logic              reg_wen;
	} lsu_req_t;

	typedef struct packed {
		logic [WADDR_W-1:0] waddr;
		logic               we;
		logic [STRB_W-1:0]  wstrb;
		logic [XLEN-1:0]    wdata;
	} mem_req_t;

	typedef struct packed {
		logic [XLEN-1:0] rdata;
		logic            err;
		logic            we;
	} mem_rsp_t;

	typedef struct packed {
		logic [4:0]      rd;
		logic            reg_wen;
		logic [XLEN-1:0] val;
		logic            err;
	} wb_t;

endpackage

//--- rtl/lsu_core.sv
`timescale 1ns/1ps

module lsu_core import lsu_pkg::*; (
	input  logic     clock,
	input  logic     arst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output mem_req_t mreq,
	output logic     mreq_valid,
	input  logic     mreq_ready,
	input  mem_rsp_t mrsp,
	input  logic     mrsp_valid,
	output wb_t      wb,
	output logic     wb_valid,
	input  logic     wb_ready
);

	lsu_state_e      state;
	lsu_req_t        req_q;
	wb_t             wb_q;
	logic [1:0]      offset;
	logic            is_store;
	logic [3:0]      size_mask;
	logic [XLEN-1:0] load_shift;
	logic [XLEN-1:0] load_val;

	// ########################################
	// Control
	// ########################################

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (req_valid) begin
						state <= (req.op == OP_PASS) ? S_WB : S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (mreq_ready) begin
						state <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (mrsp_valid) begin
						state <= S_WB;
					end
				end
				S_WB: begin
					if (wb_ready) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	assign req_ready  = (state == S_IDLE);
	assign mreq_valid = (state == S_ISSUE);
	assign wb_valid   = (state == S_WB);
	assign wb         = wb_q;

	// ########################################
	// Datapath
	// ########################################

	assign offset   = req_q.addr[1:0];
	assign is_store = req_q.op inside {OP_SB, OP_SH, OP_SW};

	always_comb begin
		case (req_q.op)
			OP_LB, OP_LBU, OP_SB: size_mask = 4'b0001;
			OP_LH, OP_LHU, OP_SH: size_mask = 4'b0011;
			default:              size_mask = 4'b1111;
		endcase
	end

	always_comb begin
		mreq.waddr = req_q.addr[XLEN-1:2];
		mreq.we    = is_store;
		mreq.wstrb = is_store ? (size_mask << offset) : '0;
		mreq.wdata = req_q.wdata << {offset, 3'b000};   // Move store data into its lane
	end

	assign load_shift = mrsp.rdata >> {offset, 3'b000};

	always_comb begin
		case (req_q.op)
			OP_LB:   load_val = {{24{load_shift[7]}}, load_shift[7:0]};
			OP_LH:   load_val = {{16{load_shift[15]}}, load_shift[15:0]};
			OP_LBU:  load_val = {24'b0, load_shift[7:0]};
			OP_LHU:  load_val = {16'b0, load_shift[15:0]};
			default: load_val = load_shift;
		endcase
	end

	// Record is filled at acceptance and completed by the memory response
	always_ff @(posedge clock) begin
		if (state == S_IDLE && req_valid) begin
			req_q <= req;
			wb_q  <= '{rd: req.rd, reg_wen: req.reg_wen, val: req.alu_val, err: 1'b0};
		end else if (state == S_WAIT && mrsp_valid) begin
			wb_q.rd      <= req_q.rd;
			wb_q.reg_wen <= !is_store && req_q.reg_wen && !mrsp.err;
			wb_q.val     <= (is_store || mrsp.err) ? '0 : load_val;
			wb_q.err     <= mrsp.err;
		end
	end

	// Execute must hold the operation until it is taken
	a_req_stable: assert property (@(posedge clock) disable iff (!arst_n)
		req_valid && !req_ready |=> !req_valid || $stable(req))
		else $error("req changed while waiting for req_ready");

	// The memory side never answers without an access in flight
	a_rsp_in_wait: assert property (@(posedge clock) disable iff (!arst_n)
		mrsp_valid |-> state == S_WAIT)
		else $error("mrsp_valid outside S_WAIT");

	// A bank reply reports the kind of access that was issued
	a_rsp_kind: assert property (@(posedge clock) disable iff (!arst_n)
		mrsp_valid && !mrsp.err |-> mrsp.we == is_store)
		else $error("mrsp.we does not match the operation");

endmodule

//--- rtl/bank_router.sv
`timescale 1ns/1ps

module bank_router import lsu_pkg::*; #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic                         clock,
	input  logic                         arst_n,
	input  mem_req_t                     mreq,
	input  logic                         mreq_valid,
	output logic                         mreq_ready,
	output mem_req_t                     bank_req,
	output logic [NUM_BANKS-1:0]         bank_req_valid,
	output logic [$clog2(NUM_BANKS)-1:0] sel_bank,
	output logic                         err_valid
);

	localparam int SEL_W = $clog2(NUM_BANKS);
	localparam int ROW_W = WADDR_W - SEL_W;

	logic [SEL_W-1:0] bank_idx;
	logic [ROW_W-1:0] row;
	logic             in_range;
	logic             accept;

	// ########################################
	// Decode
	// ########################################

	assign mreq_ready = 1'b1;                         // Banks take any request, one at a time
	assign accept     = mreq_valid && mreq_ready;
	assign bank_idx   = mreq.waddr[SEL_W-1:0];       // Consecutive words go to consecutive banks
	assign row        = mreq.waddr[WADDR_W-1:SEL_W];
	assign in_range   = (row < BANK_WORDS);

	always_comb begin
		bank_req       = mreq;
		bank_req.waddr = WADDR_W'(row);               // Banks only see their own row
	end

	always_comb begin
		bank_req_valid = '0;
		if (accept && in_range) begin
			bank_req_valid[bank_idx] = 1'b1;
		end
	end

	// ########################################
	// Reply bookkeeping
	// ########################################

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			sel_bank  <= '0;
			err_valid <= 1'b0;
		end else begin
			err_valid <= accept && !in_range;         // Stands in for the bank's one-cycle reply
			if (accept) begin
				sel_bank <= bank_idx;
			end
		end
	end

endmodule

//--- rtl/mem_bank.sv
`timescale 1ns/1ps

module mem_bank import lsu_pkg::*; #(
	parameter int BANK_WORDS = 64
) (
	input  logic     clock,
	input  logic     arst_n,
	input  mem_req_t bank_req,
	input  logic     bank_req_valid,
	output mem_rsp_t bank_rsp,
	output logic     bank_rsp_valid
);

	localparam int ROW_W = $clog2(BANK_WORDS);

	logic [XLEN-1:0]  mem [BANK_WORDS];
	logic [ROW_W-1:0] row;
	logic [XLEN-1:0]  rdata_q;
	logic             we_q;
	bank_state_e      state;

	assign row = bank_req.waddr[ROW_W-1:0];

	// ########################################
	// Storage
	// ########################################

	always_ff @(posedge clock) begin
		if (bank_req_valid) begin
			we_q <= bank_req.we;
			if (bank_req.we) begin
				for (int i = 0; i < STRB_W; i++) begin
					if (bank_req.wstrb[i]) begin
						mem[row][8*i +: 8] <= bank_req.wdata[8*i +: 8];   // Only strobed lanes
					end
				end
			end else begin
				rdata_q <= mem[row];
			end
		end
	end

	// ########################################
	// Reply sequencing
	// ########################################

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= BANK_IDLE;
		end else begin
			case (state)
				BANK_IDLE: begin
					if (bank_req_valid) begin
						state <= BANK_RESP;
					end
				end
				BANK_RESP: state <= BANK_IDLE;   // Reply lasts exactly one cycle
				default:   state <= BANK_IDLE;
			endcase
		end
	end

	assign bank_rsp_valid = (state == BANK_RESP);
	assign bank_rsp       = '{rdata: rdata_q, err: 1'b0, we: we_q};

	// The LSU keeps a single access outstanding, so a bank is never hit mid-reply
	a_no_req_in_resp: assert property (@(posedge clock) disable iff (!arst_n)
		bank_req_valid |-> state == BANK_IDLE)
		else $error("bank request while a reply is pending");

endmodule

//--- rtl/resp_merger.sv
`timescale 1ns/1ps

module resp_merger import lsu_pkg::*; #(
	parameter int NUM_BANKS = 4
) (
	input  logic [$clog2(NUM_BANKS)-1:0] sel_bank,
	input  logic                         err_valid,
	input  mem_rsp_t                     bank_rsp [NUM_BANKS],
	input  logic [NUM_BANKS-1:0]         bank_rsp_valid,
	output mem_rsp_t                     mrsp,
	output logic                         mrsp_valid
);

	logic any_bank_valid;

	assign any_bank_valid = |bank_rsp_valid;
	assign mrsp_valid     = err_valid || any_bank_valid;

	// ########################################
	// Select
	// ########################################

	always_comb begin
		if (err_valid) begin
			mrsp.rdata = '0;
			mrsp.err   = 1'b1;
			mrsp.we    = 1'b0;
		end else begin
			mrsp = bank_rsp[sel_bank];           // Router latched the index at acceptance
		end
	end

	// ########################################
	// Checks
	// ########################################

	// Router error and bank replies come from one single access
	always_comb begin
		a_one_source: assert final ($onehot0({err_valid, bank_rsp_valid}))
			else $error("more than one response source active");
	end

	// A bank reply must come from the bank the router addressed
	always_comb begin
		a_sel_match: assert final (!any_bank_valid || bank_rsp_valid[sel_bank])
			else $error("reply from bank other than sel_bank");
	end

endmodule

//--- rtl/lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem import lsu_pkg::*; #(
	parameter int NUM_BANKS  = 4,
	parameter int BANK_WORDS = 64
) (
	input  logic     clock,
	input  logic     arst_n,
	input  lsu_req_t req,
	input  logic     req_valid,
	output logic     req_ready,
	output wb_t      wb,
	output logic     wb_valid,
	input  logic     wb_ready
);

	mem_req_t                     mreq;
	logic                         mreq_valid;
	logic                         mreq_ready;
	mem_rsp_t                     mrsp;
	logic                         mrsp_valid;
	mem_req_t                     bank_req;
	logic [NUM_BANKS-1:0]         bank_req_valid;
	mem_rsp_t                     bank_rsp [NUM_BANKS];
	logic [NUM_BANKS-1:0]         bank_rsp_valid;
	logic [$clog2(NUM_BANKS)-1:0] sel_bank;
	logic                         err_valid;

	lsu_core u_lsu_core (
		.clock      (clock),
		.arst_n     (arst_n),
		.req        (req),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.mreq       (mreq),
		.mreq_valid (mreq_valid),
		.mreq_ready (mreq_ready),
		.mrsp       (mrsp),
		.mrsp_valid (mrsp_valid),
		.wb         (wb),
		.wb_valid   (wb_valid),
		.wb_ready   (wb_ready)
	);

	bank_router #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_bank_router (
		.clock          (clock),
		.arst_n         (arst_n),
		.mreq           (mreq),
		.mreq_valid     (mreq_valid),
		.mreq_ready     (mreq_ready),
		.bank_req       (bank_req),
		.bank_req_valid (bank_req_valid),
		.sel_bank       (sel_bank),
		.err_valid      (err_valid)
	);

	// ########################################
	// Word-interleaved banks
	// ########################################

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		mem_bank #(.BANK_WORDS(BANK_WORDS)) u_mem_bank (
			.clock          (clock),
			.arst_n         (arst_n),
			.bank_req       (bank_req),
			.bank_req_valid (bank_req_valid[i]),
			.bank_rsp       (bank_rsp[i]),
			.bank_rsp_valid (bank_rsp_valid[i])
		);
	end

	resp_merger #(.NUM_BANKS(NUM_BANKS)) u_resp_merger (
		.sel_bank       (sel_bank),
		.err_valid      (err_valid),
		.bank_rsp       (bank_rsp),
		.bank_rsp_valid (bank_rsp_valid),
		.mrsp           (mrsp),
		.mrsp_valid     (mrsp_valid)
	);

endmodule

//--- include/lsu_tb_ref.svh
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

// ########################################
// Shadow memory, indexed by word address
// ########################################

logic [31:0] shadow_mem [int unsigned];

function automatic logic [31:0] shadow_read(int unsigned waddr);
	if (shadow_mem.exists(waddr)) begin
		return shadow_mem[waddr];
	end
	return 32'h0;   // Unwritten words read as zero in the model only
endfunction

function automatic logic [3:0] ref_strobe(lsu_pkg::lsu_op_e op, logic [1:0] offset);
	logic [3:0] mask;
	case (op)
		lsu_pkg::OP_SB: mask = 4'b0001;
		lsu_pkg::OP_SH: mask = 4'b0011;
		lsu_pkg::OP_SW: mask = 4'b1111;
		default:        mask = 4'b0000;
	endcase
	return mask << offset;
endfunction

// Applies an accepted store; out-of-range stores leave the model untouched
function automatic void shadow_store(lsu_pkg::lsu_req_t r, int unsigned limit_words);
	int unsigned waddr;
	logic [3:0]  strb;
	logic [31:0] word;
	logic [31:0] wdata;
	waddr = r.addr[31:2];
	strb  = ref_strobe(r.op, r.addr[1:0]);
	wdata = r.wdata << {r.addr[1:0], 3'b000};
	if (waddr >= limit_words || strb == 4'b0000) begin
		return;
	end
	word = shadow_read(waddr);
	for (int i = 0; i < 4; i++) begin
		if (strb[i]) begin
			word[8*i +: 8] = wdata[8*i +: 8];
		end
	end
	shadow_mem[waddr] = word;
endfunction

// Expected record for an operation, computed when it is accepted
function automatic lsu_pkg::wb_t expected_wb(lsu_pkg::lsu_req_t r, int unsigned limit_words);
	lsu_pkg::wb_t e;
	logic [31:0]  s;
	logic         err;
	err = (r.addr[31:2] >= limit_words);
	s   = shadow_read(r.addr[31:2]) >> {r.addr[1:0], 3'b000};
	e   = '{rd: r.rd, reg_wen: 1'b0, val: '0, err: 1'b0};
	case (r.op)
		lsu_pkg::OP_PASS: begin
			e.reg_wen = r.reg_wen;
			e.val     = r.alu_val;
		end
		lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW: e.err = err;
		default: begin
			e.err     = err;
			e.reg_wen = r.reg_wen && !err;
			case (r.op)
				lsu_pkg::OP_LB:  e.val = {{24{s[7]}}, s[7:0]};
				lsu_pkg::OP_LH:  e.val = {{16{s[15]}}, s[15:0]};
				lsu_pkg::OP_LBU: e.val = {24'b0, s[7:0]};
				lsu_pkg::OP_LHU: e.val = {16'b0, s[15:0]};
				default:         e.val = s;
			endcase
			if (err) begin
				e.val = '0;
			end
		end
	endcase
	return e;
endfunction

`endif

//--- test/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

	localparam int NUM_BANKS      = 4;
	localparam int BANK_WORDS     = 64;
	localparam int LIMIT_WORDS    = NUM_BANKS * BANK_WORDS;
	localparam int TIMEOUT_CYCLES = 300 * 8 + 200;

	logic     clock;
	logic     arst_n;
	lsu_req_t req;
	logic     req_valid;
	logic     req_ready;
	wb_t      wb;
	logic     wb_valid;
	logic     wb_ready;

	integer   seed = 32'h8801_bd6e;
	wb_t      expected_q [$];
	wb_t      exp_wb;
	wb_t      held_wb;
	logic     stall_seen;
	logic     random_mode;
	int       errors;
	int       ops_sent;
	int       wb_count;
	int       cycle_count;

	`include "lsu_tb_ref.svh"

	lsu_subsystem #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_lsu_subsystem (
		.clock     (clock),
		.arst_n    (arst_n),
		.req       (req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.wb        (wb),
		.wb_valid  (wb_valid),
		.wb_ready  (wb_ready)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	// ########################################
	// Stimulus helpers
	// ########################################

	function automatic lsu_req_t make_req(lsu_op_e op, int unsigned waddr, logic [1:0] off,
			logic [31:0] wdata, logic [4:0] rd);
		lsu_req_t r;
		r.op      = op;
		r.addr    = {waddr[29:0], off};
		r.wdata   = wdata;
		r.rd      = rd;
		r.alu_val = 32'hdead_0000 | waddr;
		r.reg_wen = 1'b1;
		return r;
	endfunction

	function automatic lsu_req_t random_req();
		lsu_req_t    r;
		int unsigned n;
		int unsigned waddr;
		n = $unsigned($random(seed)) % 48;
		if (n < 32) begin
			waddr = n;
		end else if (n < 40) begin
			waddr = 216 + n;                             // Top rows of every bank
		end else begin
			waddr = LIMIT_WORDS + n * 3;
		end
		r = make_req(lsu_op_e'(4'($unsigned($random(seed)) % 9)), waddr,
			2'($random(seed)), $random(seed), 5'($random(seed)));
		r.alu_val = $random(seed);
		r.reg_wen = 1'($random(seed));
		return r;
	endfunction

	// Called on a rising edge, returns on the edge where the DUT took the operation
	task automatic send_op(input lsu_req_t r);
		logic accepted;
		req       <= r;
		req_valid <= 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = req_ready;
			@(posedge clock);
		end
		expected_q.push_back(expected_wb(r, LIMIT_WORDS));
		shadow_store(r, LIMIT_WORDS);
		ops_sent++;
	endtask

	task automatic idle_cycles(input int n);
		if (n > 0) begin
			req_valid <= 1'b0;
			repeat (n) @(posedge clock);
		end
	endtask

	always @(posedge clock) begin
		wb_ready <= random_mode ? (($random(seed) & 3) != 0) : 1'b1;   // Stall about a quarter
	end

	// ########################################
	// Writeback comparison
	// ########################################

	always @(negedge clock) begin
		if (arst_n) begin
			if (wb_valid && req_ready) begin
				errors++;
				$display("req_ready is high while a writeback is pending at %0t", $time);
			end
			if (stall_seen && (!wb_valid || wb !== held_wb)) begin
				errors++;
				$display("Fail at %0t: wb expected %h, got %h (valid %b)", $time, held_wb, wb,
					wb_valid);
			end
			if (wb_valid && wb_ready) begin
				wb_count++;
				stall_seen = 1'b0;
				if (expected_q.size() == 0) begin
					errors++;
					$display("Writeback at %0t arrived with no operation outstanding", $time);
				end else begin
					exp_wb = expected_q.pop_front();
					if (wb.rd !== exp_wb.rd) begin
						errors++;
						$display("Fail at %0t: wb.rd expected %0d, got %0d", $time, exp_wb.rd, wb.rd);
					end
					if (wb.reg_wen !== exp_wb.reg_wen) begin
						errors++;
						$display("Fail at %0t: wb.reg_wen expected %b, got %b", $time,
							exp_wb.reg_wen, wb.reg_wen);
					end
					if (wb.val !== exp_wb.val) begin
						errors++;
						$display("Fail at %0t: wb.val expected %h, got %h", $time, exp_wb.val, wb.val);
					end
					if (wb.err !== exp_wb.err) begin
						errors++;
						$display("Fail at %0t: wb.err expected %b, got %b", $time, exp_wb.err, wb.err);
					end
				end
			end else if (wb_valid) begin
				stall_seen = 1'b1;
				held_wb    = wb;
			end else begin
				stall_seen = 1'b0;
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout after %0d cycles with %0d writebacks still missing", cycle_count,
			expected_q.size());
		$display("** FAIL **");
		$finish;
	end

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		arst_n      = 1'b0;
		req         = '0;
		req_valid   = 1'b0;
		wb_ready    = 1'b1;
		random_mode = 1'b0;
		stall_seen  = 1'b0;
		errors      = 0;
		ops_sent    = 0;
		wb_count    = 0;
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		if (req_ready !== 1'b1 || wb_valid !== 1'b0) begin
			errors++;
			$display("Handshake outputs are wrong after reset");
		end
		@(posedge clock);

		for (int w = 0; w < 40; w++) begin                // Words 0..31 and 248..255
			send_op(make_req(OP_SW, (w < 32) ? w : 216 + w, 2'd0, $random(seed), 5'(w)));
		end
		for (int w = 0; w < 40; w++) begin
			send_op(make_req(OP_LW, (w < 32) ? w : 216 + w, 2'd0, '0, 5'(w)));
		end

		for (int k = 0; k < 2; k++) begin
			for (int off = 0; off < 4; off++) begin
				send_op(make_req(OP_SB, k ? 250 : 5, 2'(off), $random(seed), 5'(off)));
			end
			for (int off = 0; off < 4; off++) begin
				send_op(make_req(OP_LB, k ? 250 : 5, 2'(off), '0, 5'(off)));
				send_op(make_req(OP_LBU, k ? 250 : 5, 2'(off), '0, 5'(off)));
			end
			for (int off = 0; off < 4; off++) begin
				send_op(make_req(OP_SH, k ? 250 : 5, 2'(off), $random(seed), 5'(off)));
			end
			for (int off = 0; off < 4; off++) begin
				send_op(make_req(OP_LH, k ? 250 : 5, 2'(off), '0, 5'(off)));
				send_op(make_req(OP_LHU, k ? 250 : 5, 2'(off), '0, 5'(off)));
			end
			send_op(make_req(OP_LW, k ? 250 : 5, 2'd0, '0, 5'd31));
		end

		for (int i = 0; i < 8; i++) begin
			send_op('{op: OP_PASS, addr: $random(seed), wdata: '0, rd: 5'(i + 20),
				alu_val: $random(seed), reg_wen: 1'(i)});
		end

		for (int k = 0; k < 4; k++) begin                 // Row past the end of every bank
			send_op(make_req(OP_SW, LIMIT_WORDS + k, 2'd0, $random(seed), 5'(k)));
			send_op(make_req(OP_LW, LIMIT_WORDS + k, 2'd0, '0, 5'(k)));
			send_op(make_req(OP_LW, k, 2'd0, '0, 5'(k)));
		end
		send_op(make_req(OP_SB, 32'h2000_0000, 2'd3, $random(seed), 5'd9));
		send_op(make_req(OP_LBU, 32'h2000_0000, 2'd3, '0, 5'd9));
		send_op(make_req(OP_LBU, 0, 2'd3, '0, 5'd9));

		random_mode <= 1'b1;
		repeat (140) begin
			send_op(random_req());
			idle_cycles($unsigned($random(seed)) % 3);
		end
		req_valid <= 1'b0;
		while (expected_q.size() != 0) begin
			@(posedge clock);
		end
		repeat (4) @(posedge clock);

		if (wb_count != ops_sent) begin
			errors++;
			$display("Operations sent and writebacks seen do not match");
		end
		$display("Operations: %0d, writebacks: %0d, errors: %0d", ops_sent, wb_count, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_core.sv
rtl/bank_router.sv
rtl/mem_bank.sv
rtl/resp_merger.sv
rtl/lsu_subsystem.sv
test/lsu_tb.sv
